// File: rtl/otp_emu_pkg.sv
// Shared types for the OTP emulation on a single-port RAM
// One native word is 16 bits and the word address is 10 bits, so Depth <= 1024
// No ECC, the raw command variants are not supported

package otp_emu_pkg;

  // Native OTP word
  localparam int NativeWidth = 16;

  // Word address width on all memory paths
  localparam int MemAddrWidth = 10;

  ////////////////////
  // Macro commands
  ////////////////////

  typedef enum logic [1:0] {
    Init  = 2'd0,
    Read  = 2'd1,
    Write = 2'd2
  } otp_cmd_e;

  typedef enum logic [1:0] {
    NoError              = 2'd0,
    // Write data would clear a programmed bit
    MacroWriteBlankError = 2'd1,
    // Controller FSM ended up in its error state
    FsmStateError        = 2'd2
  } otp_err_e;

  ////////////////////
  // Memory port
  ////////////////////

  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [MemAddrWidth-1:0] addr;
    logic [NativeWidth-1:0]  wdata;
  } mem_req_t;

  typedef struct packed {
    logic                   rvalid;
    logic [NativeWidth-1:0] rdata;
  } mem_rsp_t;

  ////////////////////
  // Backdoor port
  ////////////////////

  typedef struct packed {
    logic                    we;
    logic [MemAddrWidth-1:0] addr;
    logic [NativeWidth-1:0]  wdata;
  } bd_cmd_t;

  typedef struct packed {
    logic                   rvalid;
    logic [NativeWidth-1:0] rdata;
  } bd_rsp_t;

endpackage

// File: rtl/otp_macro_ctrl.sv
// OTP macro command FSM with Init, Read and Write of 1 to 2**SizeWidth words
// Only Init is taken after reset, other commands are consumed and dropped
// A command whose last word lies at or beyond Depth is consumed and dropped
// Writes only set bits, a clearing attempt still merges and flags the error
// The memory request is held until granted

module otp_macro_ctrl #(
  parameter int Depth     = 256,
  parameter int SizeWidth = 2
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  // Command channel
  input  logic                                                    valid_i,
  output logic                                                    ready_o,
  input  otp_emu_pkg::otp_cmd_e                                   cmd_i,
  input  logic [SizeWidth-1:0]                                    size_i,
  input  logic [otp_emu_pkg::MemAddrWidth-1:0]                    addr_i,
  input  logic [2**SizeWidth-1:0][otp_emu_pkg::NativeWidth-1:0]   wdata_i,
  // Response channel
  output logic                                                    valid_o,
  output logic [2**SizeWidth-1:0][otp_emu_pkg::NativeWidth-1:0]   rdata_o,
  output otp_emu_pkg::otp_err_e                                   err_o,
  output logic                                                    fatal_alert_o,
  // Memory client port
  output otp_emu_pkg::mem_req_t                                   mem_req_o,
  input  logic                                                    mem_gnt_i,
  input  otp_emu_pkg::mem_rsp_t                                   mem_rsp_i
);

  localparam int NumWords = 2**SizeWidth;
  localparam int AddrW    = otp_emu_pkg::MemAddrWidth;
  localparam int WordW    = otp_emu_pkg::NativeWidth;

  // Depth in the width of the range check sum
  localparam logic [AddrW:0] DepthLimit = (AddrW+1)'(Depth);

  typedef enum logic [3:0] {
    ResetSt,
    InitSt,
    IdleSt,
    ReadSt,
    ReadWaitSt,
    WriteCheckSt,
    WriteWaitSt,
    WriteSt,
    ErrorSt
  } state_e;

  state_e                state_d, state_q;
  otp_emu_pkg::otp_err_e err_d, err_q;
  logic                  valid_d, valid_q;
  logic                  req, wren, fsm_err;
  logic                  accept;
  logic                  cnt_clr, cnt_en;
  logic [SizeWidth-1:0]  cnt_d, cnt_q;
  logic [SizeWidth-1:0]  size_q;
  logic [AddrW-1:0]      addr_q, word_addr;
  logic [AddrW:0]        last_addr;
  logic                  in_range;
  logic                  last_word;
  logic [NumWords-1:0][WordW-1:0] wdata_q, rdata_q;
  logic [WordW-1:0]      old_word, new_word, merged_word;
  logic                  blank_err;

  assign accept    = ready_o && valid_i;
  assign last_word = (cnt_q == size_q);

  // Last touched word must stay inside the array
  assign last_addr = {1'b0, addr_i} + (AddrW+1)'(size_i);
  assign in_range  = (last_addr < DepthLimit);

  assign cnt_d = cnt_clr ? '0 :
                 cnt_en  ? cnt_q + 1'b1 : cnt_q;

  assign word_addr = addr_q + AddrW'(cnt_q);

  // Read-modify-write, OTP bits can only go from 0 to 1
  assign old_word    = rdata_q[cnt_q];
  assign new_word    = wdata_q[cnt_q];
  assign merged_word = old_word | new_word;
  assign blank_err   = ((old_word & new_word) != old_word);

  assign valid_o       = valid_q;
  assign err_o         = err_q;
  assign rdata_o       = rdata_q;
  assign fatal_alert_o = fsm_err;

  ////////////////////
  // Control FSM
  ////////////////////

  always_comb begin : p_fsm
    state_d = state_q;
    err_d   = err_q;
    valid_d = 1'b0;
    ready_o = 1'b0;
    req     = 1'b0;
    wren    = 1'b0;
    cnt_clr = 1'b0;
    cnt_en  = 1'b0;
    fsm_err = 1'b0;

    case (state_q)
      // Wait for Init, anything else is swallowed
      ResetSt: begin
        ready_o = 1'b1;
        err_d   = otp_emu_pkg::NoError;
        if (valid_i && (cmd_i == otp_emu_pkg::Init)) begin
          state_d = InitSt;
        end
      end
      // Macro ready one cycle later
      InitSt: begin
        valid_d = 1'b1;
        state_d = IdleSt;
      end
      IdleSt: begin
        ready_o = 1'b1;
        if (valid_i && in_range) begin
          case (cmd_i)
            otp_emu_pkg::Read: begin
              cnt_clr = 1'b1;
              err_d   = otp_emu_pkg::NoError;
              state_d = ReadSt;
            end
            otp_emu_pkg::Write: begin
              cnt_clr = 1'b1;
              err_d   = otp_emu_pkg::NoError;
              state_d = WriteCheckSt;
            end
            default: ;
          endcase
        end
      end
      // Issue one word read, hold until granted
      ReadSt: begin
        req = 1'b1;
        if (mem_gnt_i) begin
          state_d = ReadWaitSt;
        end
      end
      ReadWaitSt: begin
        if (mem_rsp_i.rvalid) begin
          if (last_word) begin
            valid_d = 1'b1;
            state_d = IdleSt;
          end else begin
            cnt_en  = 1'b1;
            state_d = ReadSt;
          end
        end
      end
      // Fetch all old words before any write
      WriteCheckSt: begin
        req = 1'b1;
        if (mem_gnt_i) begin
          state_d = WriteWaitSt;
        end
      end
      WriteWaitSt: begin
        if (mem_rsp_i.rvalid) begin
          if (last_word) begin
            cnt_clr = 1'b1;
            state_d = WriteSt;
          end else begin
            cnt_en  = 1'b1;
            state_d = WriteCheckSt;
          end
        end
      end
      // Merged write per word
      WriteSt: begin
        req  = 1'b1;
        wren = 1'b1;
        if (mem_gnt_i) begin
          if (blank_err) begin
            err_d = otp_emu_pkg::MacroWriteBlankError;
          end
          if (last_word) begin
            valid_d = 1'b1;
            state_d = IdleSt;
          end else begin
            cnt_en = 1'b1;
          end
        end
      end
      // Terminal, only reset leaves
      ErrorSt: begin
        fsm_err = 1'b1;
        err_d   = otp_emu_pkg::FsmStateError;
      end
      default: begin
        fsm_err = 1'b1;
        err_d   = otp_emu_pkg::FsmStateError;
        state_d = ErrorSt;
      end
    endcase
  end

  // Request fields idle at zero
  always_comb begin : p_mem_req
    mem_req_o       = '0;
    mem_req_o.req   = req;
    mem_req_o.we    = wren;
    mem_req_o.addr  = req ? word_addr : '0;
    mem_req_o.wdata = wren ? merged_word : '0;
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_regs
    if (!rst_ni) begin
      state_q <= ResetSt;
      err_q   <= otp_emu_pkg::NoError;
      valid_q <= 1'b0;
      cnt_q   <= '0;
      addr_q  <= '0;
      size_q  <= '0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
      valid_q <= valid_d;
      cnt_q   <= cnt_d;
      if (accept) begin
        addr_q <= addr_i;
        size_q <= size_i;
      end
    end
  end

  // Command data and read words
  always_ff @(posedge clk_i) begin : p_data_regs
    if (accept) begin
      wdata_q <= wdata_i;
    end
    // Only reads of this client come back here
    if (mem_rsp_i.rvalid) begin
      rdata_q[cnt_q] <= mem_rsp_i.rdata;
    end
  end

endmodule

// File: rtl/otp_backdoor_port.sv
// Single-word backdoor access with a one-cycle strobe and no back-pressure
// Read data returns 2 cycles after the strobe, writes overwrite the word
// A strobe while a command is pending is dropped and flagged on overrun_o

module otp_backdoor_port (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Strobe side
  input  logic                  bd_req_i,
  input  otp_emu_pkg::bd_cmd_t  bd_cmd_i,
  output otp_emu_pkg::bd_rsp_t  bd_rsp_o,
  output logic                  overrun_o,
  // Memory client port
  output otp_emu_pkg::mem_req_t mem_req_o,
  input  logic                  mem_gnt_i,
  input  otp_emu_pkg::mem_rsp_t mem_rsp_i
);

  logic                  pend_q;
  logic                  rd_out_q;
  logic                  accept;
  logic                  rsp_valid;
  otp_emu_pkg::bd_cmd_t  cmd_q;
  logic [otp_emu_pkg::NativeWidth-1:0] rdata_q;

  // One command slot
  assign accept    = bd_req_i && !pend_q;
  assign overrun_o = bd_req_i && pend_q;

  // Response only for a read this port issued
  assign rsp_valid = mem_rsp_i.rvalid && rd_out_q;

  always_comb begin : p_mem_req
    mem_req_o = '0;
    if (pend_q) begin
      mem_req_o.req   = 1'b1;
      mem_req_o.we    = cmd_q.we;
      mem_req_o.addr  = cmd_q.addr;
      mem_req_o.wdata = cmd_q.wdata;
    end
  end

  // Fresh data on the response cycle, held afterwards
  assign bd_rsp_o.rvalid = rsp_valid;
  assign bd_rsp_o.rdata  = rsp_valid ? mem_rsp_i.rdata : rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_regs
    if (!rst_ni) begin
      pend_q   <= 1'b0;
      rd_out_q <= 1'b0;
    end else begin
      if (accept) begin
        pend_q <= 1'b1;
      end else if (mem_gnt_i) begin
        pend_q <= 1'b0;
      end
      // Read in flight until its data returns
      if (mem_gnt_i && !cmd_q.we) begin
        rd_out_q <= 1'b1;
      end else if (mem_rsp_i.rvalid) begin
        rd_out_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_data_regs
    if (accept) begin
      cmd_q <= bd_cmd_i;
    end
    if (rsp_valid) begin
      rdata_q <= mem_rsp_i.rdata;
    end
  end

endmodule

// File: rtl/otp_mem_arbiter.sv
// Fixed-priority arbiter of two clients onto one RAM port
// The backdoor always wins, the controller waits while it requests
// Read data goes back only to the client that issued the read

module otp_mem_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Clients
  input  otp_emu_pkg::mem_req_t bd_req_i,
  input  otp_emu_pkg::mem_req_t ctrl_req_i,
  output logic                  bd_gnt_o,
  output logic                  ctrl_gnt_o,
  // RAM side
  output otp_emu_pkg::mem_req_t mem_req_o,
  input  otp_emu_pkg::mem_rsp_t mem_rsp_i,
  // Routed responses
  output otp_emu_pkg::mem_rsp_t bd_rsp_o,
  output otp_emu_pkg::mem_rsp_t ctrl_rsp_o
);

  // Set when the last granted read came from the backdoor
  logic owner_bd_q;
  logic rd_granted;

  assign bd_gnt_o   = bd_req_i.req;
  assign ctrl_gnt_o = ctrl_req_i.req && !bd_req_i.req;

  always_comb begin : p_mux
    if (bd_gnt_o) begin
      mem_req_o = bd_req_i;
    end else if (ctrl_gnt_o) begin
      mem_req_o = ctrl_req_i;
    end else begin
      mem_req_o = '0;
    end
  end

  assign rd_granted = mem_req_o.req && !mem_req_o.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_owner
    if (!rst_ni) begin
      owner_bd_q <= 1'b0;
    end else if (rd_granted) begin
      owner_bd_q <= bd_gnt_o;
    end
  end

  // Data bus shared, rvalid steered by owner
  assign bd_rsp_o.rvalid   = mem_rsp_i.rvalid && owner_bd_q;
  assign bd_rsp_o.rdata    = mem_rsp_i.rdata;
  assign ctrl_rsp_o.rvalid = mem_rsp_i.rvalid && !owner_bd_q;
  assign ctrl_rsp_o.rdata  = mem_rsp_i.rdata;

endmodule

// File: rtl/otp_array.sv
// Single-port word RAM with registered read data, rvalid one cycle after a read
// Depth must be between 2 and 1024, addresses at or above Depth read as zero
// and drop writes. Content starts at zero

module otp_array #(
  parameter int Depth = 256
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  otp_emu_pkg::mem_req_t mem_req_i,
  output otp_emu_pkg::mem_rsp_t mem_rsp_o
);

  localparam int AddrW = $clog2(Depth);
  localparam int ReqAddrW = otp_emu_pkg::MemAddrWidth;
  localparam logic [ReqAddrW:0] DepthLimit = (ReqAddrW+1)'(Depth);

  logic [otp_emu_pkg::NativeWidth-1:0] mem_q [Depth];
  logic [otp_emu_pkg::NativeWidth-1:0] rdata_q;
  logic                                rvalid_q;
  logic                                in_range;
  logic [AddrW-1:0]                    idx;

  assign in_range = ({1'b0, mem_req_i.addr} < DepthLimit);
  assign idx      = mem_req_i.addr[AddrW-1:0];

  // Blank fuses
  initial begin
    for (int i = 0; i < Depth; i++) begin
      mem_q[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (mem_req_i.req) begin
      if (mem_req_i.we) begin
        if (in_range) begin
          mem_q[idx] <= mem_req_i.wdata;
        end
      end else begin
        rdata_q <= in_range ? mem_q[idx] : '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rvalid
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= mem_req_i.req && !mem_req_i.we;
    end
  end

  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.rdata  = rdata_q;

endmodule

// File: rtl/otp_emu_top.sv
// OTP macro emulation, command controller and backdoor sharing one RAM
// Backdoor has priority and may stall macro commands
// Depth at most 1024 words, up to 2**SizeWidth words per macro command

module otp_emu_top #(
  parameter int Depth     = 256,
  parameter int SizeWidth = 2
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  // Macro command side
  input  logic                                                  valid_i,
  output logic                                                  ready_o,
  input  otp_emu_pkg::otp_cmd_e                                 cmd_i,
  input  logic [SizeWidth-1:0]                                  size_i,
  input  logic [otp_emu_pkg::MemAddrWidth-1:0]                  addr_i,
  input  logic [2**SizeWidth-1:0][otp_emu_pkg::NativeWidth-1:0] wdata_i,
  output logic                                                  valid_o,
  output logic [2**SizeWidth-1:0][otp_emu_pkg::NativeWidth-1:0] rdata_o,
  output otp_emu_pkg::otp_err_e                                 err_o,
  output logic                                                  fatal_alert_o,
  // Backdoor side
  input  logic                                                  bd_req_i,
  input  otp_emu_pkg::bd_cmd_t                                  bd_cmd_i,
  output otp_emu_pkg::bd_rsp_t                                  bd_rsp_o,
  output logic                                                  overrun_o
);

  otp_emu_pkg::mem_req_t ctrl_mem_req, bd_mem_req, arr_req;
  otp_emu_pkg::mem_rsp_t ctrl_mem_rsp, bd_mem_rsp, arr_rsp;
  logic                  ctrl_gnt, bd_gnt;

  otp_macro_ctrl #(
    .Depth     (Depth),
    .SizeWidth (SizeWidth)
  ) i_macro_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .cmd_i         (cmd_i),
    .size_i        (size_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o),
    .err_o         (err_o),
    .fatal_alert_o (fatal_alert_o),
    .mem_req_o     (ctrl_mem_req),
    .mem_gnt_i     (ctrl_gnt),
    .mem_rsp_i     (ctrl_mem_rsp)
  );

  otp_backdoor_port i_backdoor_port (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bd_req_i  (bd_req_i),
    .bd_cmd_i  (bd_cmd_i),
    .bd_rsp_o  (bd_rsp_o),
    .overrun_o (overrun_o),
    .mem_req_o (bd_mem_req),
    .mem_gnt_i (bd_gnt),
    .mem_rsp_i (bd_mem_rsp)
  );

  otp_mem_arbiter i_mem_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bd_req_i   (bd_mem_req),
    .ctrl_req_i (ctrl_mem_req),
    .bd_gnt_o   (bd_gnt),
    .ctrl_gnt_o (ctrl_gnt),
    .mem_req_o  (arr_req),
    .mem_rsp_i  (arr_rsp),
    .bd_rsp_o   (bd_mem_rsp),
    .ctrl_rsp_o (ctrl_mem_rsp)
  );

  otp_array #(
    .Depth (Depth)
  ) i_array (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mem_req_i (arr_req),
    .mem_rsp_o (arr_rsp)
  );

endmodule

// File: tests/otp_emu_assertions.sv
// Protocol and timing checks on the OTP emulation top level
// Backdoor read latency holds because the backdoor always wins the RAM
// Checks are idle while rst_ni is low

module otp_emu_assertions (
  input logic                 clk_i,
  input logic                 rst_ni,
  // Macro command side
  input logic                 cmd_ready_i,
  input logic                 rsp_valid_i,
  input logic                 fatal_alert_i,
  // Backdoor side
  input logic                 bd_req_i,
  input otp_emu_pkg::bd_cmd_t bd_cmd_i,
  input otp_emu_pkg::bd_rsp_t bd_rsp_i,
  input logic                 overrun_i,
  // Arbiter grants
  input logic                 bd_gnt_i,
  input logic                 ctrl_gnt_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of fired checks
  int unsigned fail_count;

  // Read strobe taken by the backdoor port
  logic bd_rd_accept;

  assign bd_rd_accept = bd_req_i && !overrun_i && !bd_cmd_i.we;

  ////////////////////
  // Backdoor timing
  ////////////////////

  bd_rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(bd_rd_accept, 2) |-> bd_rsp_i.rvalid)
    else begin
      fail_count++;
      $error("backdoor read data missing 2 cycles after the read strobe");
    end

  bd_rvalid_only_for_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bd_rsp_i.rvalid |-> $past(bd_rd_accept, 2))
    else begin
      fail_count++;
      $error("backdoor rvalid without a read strobe 2 cycles earlier");
    end

  // Overrun exactly when a strobe follows a taken strobe
  overrun_on_back_to_back: assert property (@(posedge clk_i) disable iff (!rst_ni)
    overrun_i == (bd_req_i && $past(bd_req_i && !overrun_i)))
    else begin
      fail_count++;
      $error("overrun does not match a strobe right after a taken strobe");
    end

  ////////////////////
  // Macro handshake
  ////////////////////

  // Busy until the response
  ready_returns_with_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_ready_i) |-> rsp_valid_i)
    else begin
      fail_count++;
      $error("macro ready returned without a response");
    end

  rsp_after_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> !$past(cmd_ready_i))
    else begin
      fail_count++;
      $error("macro response while the controller was not busy");
    end

  rsp_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |=> !rsp_valid_i)
    else begin
      fail_count++;
      $error("macro response valid longer than one cycle");
    end

  no_fatal_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fatal_alert_i)
    else begin
      fail_count++;
      $error("macro controller raised its fatal alert");
    end

  // One RAM owner per cycle
  single_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bd_gnt_i && ctrl_gnt_i))
    else begin
      fail_count++;
      $error("both clients granted in the same cycle");
    end

endmodule

bind otp_emu_top otp_emu_assertions i_otp_emu_assertions (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .cmd_ready_i   (ready_o),
  .rsp_valid_i   (valid_o),
  .fatal_alert_i (fatal_alert_o),
  .bd_req_i      (bd_req_i),
  .bd_cmd_i      (bd_cmd_i),
  .bd_rsp_i      (bd_rsp_o),
  .overrun_i     (overrun_o),
  .bd_gnt_i      (bd_gnt),
  .ctrl_gnt_i    (ctrl_gnt)
);

// File: tests/otp_emu_tb.sv
// Directed and random tests of the OTP emulation top level
// Reference memory covers the default Depth of 256 words, test regions are fixed
// Inputs change 2 ns after the rising edge, outputs are read at that point

module otp_emu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int Depth     = 256;
  localparam int SizeWidth = 2;
  localparam int NumWords  = 2**SizeWidth;
  localparam int IdxW      = $clog2(Depth);
  localparam int AddrW     = otp_emu_pkg::MemAddrWidth;
  localparam int WordW     = otp_emu_pkg::NativeWidth;
  // Cycle limit of each wait loop
  localparam int Timeout   = 50;

  typedef logic [NumWords-1:0][WordW-1:0] words_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  valid_i;
  logic                  ready_o;
  otp_emu_pkg::otp_cmd_e cmd_i;
  logic [SizeWidth-1:0]  size_i;
  logic [AddrW-1:0]      addr_i;
  words_t                wdata_i;
  logic                  valid_o;
  words_t                rdata_o;
  otp_emu_pkg::otp_err_e err_o;
  logic                  fatal_alert_o;
  logic                  bd_req_i;
  otp_emu_pkg::bd_cmd_t  bd_cmd_i;
  otp_emu_pkg::bd_rsp_t  bd_rsp_o;
  logic                  overrun_o;

  // Reference memory, backdoor overwrites and macro writes OR in
  logic [WordW-1:0] model_mem [Depth];
  logic [31:0]      rng_state;
  logic             seen;
  int               cycles;
  logic [31:0]      r;
  words_t           wdata;

  otp_emu_top #(
    .Depth     (Depth),
    .SizeWidth (SizeWidth)
  ) i_otp_emu_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .cmd_i         (cmd_i),
    .size_i        (size_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o),
    .err_o         (err_o),
    .fatal_alert_o (fatal_alert_o),
    .bd_req_i      (bd_req_i),
    .bd_cmd_i      (bd_cmd_i),
    .bd_rsp_o      (bd_rsp_o),
    .overrun_o     (overrun_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [WordW-1:0] got,
                            input logic [WordW-1:0] exp);
    assert (got === exp)
      else stop_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
      else stop_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    assert (got == exp)
      else stop_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_err(input otp_emu_pkg::otp_err_e exp);
    assert (err_o === exp)
      else stop_run($sformatf("[FAIL] err_o got 0x%0h expected 0x%0h", err_o, exp));
  endtask

  // xorshift32 stream
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  ////////////////////
  // Backdoor driver
  ////////////////////

  // One-cycle strobe, returns in the cycle after it
  task automatic bd_strobe(input logic we, input logic [IdxW-1:0] a,
                           input logic [WordW-1:0] d);
    bd_req_i       = 1'b1;
    bd_cmd_i.we    = we;
    bd_cmd_i.addr  = AddrW'(a);
    bd_cmd_i.wdata = d;
    next_cycle();
    bd_req_i = 1'b0;
  endtask

  // Leaves a free cycle so the next strobe is not an overrun
  task automatic bd_write(input logic [IdxW-1:0] a, input logic [WordW-1:0] d);
    bd_strobe(1'b1, a, d);
    model_mem[a] = d;
    next_cycle();
  endtask

  task automatic bd_read_check(input logic [IdxW-1:0] a);
    int waited;
    bd_strobe(1'b0, a, '0);
    waited = 1;
    while (!bd_rsp_o.rvalid && waited < Timeout) begin
      next_cycle();
      waited++;
    end
    if (!bd_rsp_o.rvalid) stop_run("backdoor read returned no data before its timeout");
    check_word("bd_rsp_o.rdata", bd_rsp_o.rdata, model_mem[a]);
  endtask

  // Read strobe every other cycle, data due at the next strobe
  task automatic bd_read_stream(input logic [IdxW-1:0] base);
    logic [IdxW-1:0] a;
    logic [IdxW-1:0] prev;
    prev = base;
    for (int n = 0; n < 16; n++) begin
      if (n > 0) begin
        check_bit("bd_rsp_o.rvalid", bd_rsp_o.rvalid, 1'b1);
        check_word("bd_rsp_o.rdata", bd_rsp_o.rdata, model_mem[prev]);
      end
      a = base + IdxW'(n % 8);
      bd_strobe(1'b0, a, '0);
      prev = a;
      next_cycle();
    end
    check_bit("bd_rsp_o.rvalid", bd_rsp_o.rvalid, 1'b1);
    check_word("bd_rsp_o.rdata", bd_rsp_o.rdata, model_mem[prev]);
  endtask

  ////////////////////
  // Macro driver
  ////////////////////

  task automatic macro_issue(input otp_emu_pkg::otp_cmd_e cmd, input logic [SizeWidth-1:0] size,
                             input logic [IdxW-1:0] a, input words_t data);
    int waited;
    valid_i = 1'b1;
    cmd_i   = cmd;
    size_i  = size;
    addr_i  = AddrW'(a);
    wdata_i = data;
    waited  = 0;
    while (!ready_o && waited < Timeout) begin
      next_cycle();
      waited++;
    end
    if (!ready_o) stop_run("macro command was never accepted");
    next_cycle();
    valid_i = 1'b0;
  endtask

  // Counts cycles from acceptance, the first cycle after it is 1
  task automatic macro_wait(input int limit, output logic got, output int lat);
    lat = 1;
    while (!valid_o && lat < limit) begin
      next_cycle();
      lat++;
    end
    got = valid_o;
  endtask

  task automatic macro_read_check(input logic [IdxW-1:0] base,
                                  input logic [SizeWidth-1:0] size);
    logic                 got;
    int                   lat;
    logic [IdxW-1:0]      a;
    logic [SizeWidth-1:0] wi;
    macro_issue(otp_emu_pkg::Read, size, base, '0);
    macro_wait(Timeout, got, lat);
    if (!got) stop_run("macro Read got no response before its timeout");
    check_err(otp_emu_pkg::NoError);
    for (int i = 0; i <= int'(size); i++) begin
      a  = base + IdxW'(i);
      wi = SizeWidth'(i);
      check_word($sformatf("rdata_o[%0d]", i), rdata_o[wi], model_mem[a]);
    end
  endtask

  // Blank error when a programmed bit is missing from the new data
  task automatic macro_write_check(input logic [IdxW-1:0] base,
                                   input logic [SizeWidth-1:0] size, input words_t data);
    logic                 got;
    int                   lat;
    logic [IdxW-1:0]      a;
    logic [SizeWidth-1:0] wi;
    logic                 blank;
    blank = 1'b0;
    for (int i = 0; i <= int'(size); i++) begin
      a  = base + IdxW'(i);
      wi = SizeWidth'(i);
      if ((model_mem[a] & ~data[wi]) != '0) blank = 1'b1;
      model_mem[a] = model_mem[a] | data[wi];
    end
    macro_issue(otp_emu_pkg::Write, size, base, data);
    macro_wait(Timeout, got, lat);
    if (!got) stop_run("macro Write got no response before its timeout");
    if (blank) check_err(otp_emu_pkg::MacroWriteBlankError);
    else check_err(otp_emu_pkg::NoError);
  endtask

  // Any fired bound check ends the run
  always @(negedge clk_i) begin : assertion_monitor
    if (i_otp_emu_top.i_otp_emu_assertions.fail_count != 0) begin
      stop_run("a bound protocol assertion failed");
    end
  end

  initial begin : watchdog
    #500000;
    stop_run("simulation ran past its overall time limit");
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    rng_state = 32'd5;
    valid_i   = 1'b0;
    cmd_i     = otp_emu_pkg::Init;
    size_i    = '0;
    addr_i    = '0;
    wdata_i   = '0;
    bd_req_i  = 1'b0;
    bd_cmd_i  = '0;
    for (int i = 0; i < Depth; i++) model_mem[i] = '0;
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Reset state, Read ignored before Init, Init latency
    check_bit("ready_o", ready_o, 1'b1);
    check_bit("valid_o", valid_o, 1'b0);
    macro_issue(otp_emu_pkg::Read, 2'd0, 8'h00, '0);
    macro_wait(20, seen, cycles);
    check_bit("valid_o", seen, 1'b0);
    macro_issue(otp_emu_pkg::Init, 2'd0, 8'h00, '0);
    macro_wait(Timeout, seen, cycles);
    if (!seen) stop_run("macro Init got no response before its timeout");
    check_count("init latency", cycles, 2);
    check_err(otp_emu_pkg::NoError);

    // Random preload, then reads of random size
    for (int k = 0; k < 24; k++) begin
      r = next_rand();
      bd_write(IdxW'(16 + int'(r[4:0])), r[31:16]);
    end
    for (int k = 0; k < 10; k++) begin
      r = next_rand();
      macro_read_check(IdxW'(16 + int'(r[6:2])), r[1:0]);
    end

    // Covering write, then a write that would clear a bit
    r = next_rand();
    bd_write(8'h40, r[15:0] | 16'h0001);
    r = next_rand();
    wdata    = '0;
    wdata[0] = model_mem[8'h40] | r[15:0];
    macro_write_check(8'h40, 2'd0, wdata);
    check_err(otp_emu_pkg::NoError);
    bd_read_check(8'h40);
    r = next_rand();
    wdata[0] = ~model_mem[8'h40] & r[15:0];
    wdata[1] = r[31:16];
    macro_write_check(8'h40, 2'd1, wdata);
    check_err(otp_emu_pkg::MacroWriteBlankError);
    bd_read_check(8'h40);
    bd_read_check(8'h41);

    // Backdoor write may clear bits
    bd_write(8'hd0, 16'hffff);
    r = next_rand();
    bd_write(8'hd0, r[15:0] & 16'h0ff0);
    bd_read_check(8'hd0);

    // Four-word macro commands under backdoor traffic
    for (int k = 0; k < 8; k++) begin
      r = next_rand();
      bd_write(IdxW'(8'h80 + k), r[15:0]);
      bd_write(IdxW'(8'h90 + k), r[31:16] & 16'h00ff);
      bd_write(IdxW'(8'ha0 + k), r[23:8]);
    end
    fork
      macro_read_check(8'h80, 2'd3);
      bd_read_stream(8'ha0);
    join
    for (int k = 0; k < NumWords; k++) begin
      r = next_rand();
      wdata[SizeWidth'(k)] = r[15:0];
    end
    fork
      macro_write_check(8'h90, 2'd3, wdata);
      bd_read_stream(8'ha0);
    join
    macro_read_check(8'h90, 2'd3);

    // Back-to-back strobes, the second is dropped
    r = next_rand();
    bd_req_i       = 1'b1;
    bd_cmd_i.we    = 1'b1;
    bd_cmd_i.addr  = AddrW'(8'hc0);
    bd_cmd_i.wdata = r[15:0];
    #5;
    check_bit("overrun_o", overrun_o, 1'b0);
    next_cycle();
    model_mem[8'hc0] = r[15:0];
    bd_cmd_i.addr  = AddrW'(8'hc1);
    bd_cmd_i.wdata = r[31:16] | 16'h0001;
    #5;
    check_bit("overrun_o", overrun_o, 1'b1);
    next_cycle();
    bd_req_i = 1'b0;
    bd_read_check(8'hc0);
    bd_read_check(8'hc1);

    for (int k = 0; k < 4; k++) next_cycle();
    if (i_otp_emu_top.i_otp_emu_assertions.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: otp_emu.f
rtl/otp_emu_pkg.sv
rtl/otp_macro_ctrl.sv
rtl/otp_backdoor_port.sv
rtl/otp_mem_arbiter.sv
rtl/otp_array.sv
rtl/otp_emu_top.sv
tests/otp_emu_assertions.sv
tests/otp_emu_tb.sv

// File: Makefile
TOP := otp_emu_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): otp_emu.f $(wildcard rtl/*.sv tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f otp_emu.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f otp_emu.f

clean:
	rm -rf obj_dir
